/* include/soc_bus_defs.svh */
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// RAM region, 1024 words of 32 bits
`define RAM_BASE      32'h0000_1000
`define RAM_WORDS     1024

// Single-word device registers
`define KEY_ADDR      32'h0000_8000
`define UART_ADDR     32'h0000_8004
`define SD_ADDR_REG   32'h0000_8010
`define SD_READ_REG   32'h0000_8014
`define SD_READY_REG  32'h0000_8018
`define SD_AVAIL_REG  32'h0000_801C

// SD sector buffer window
`define SD_BUF_BASE   32'h0000_9000
`define SD_BUF_BYTES  512

// Load kinds, anything else is a word load
`define LOAD_B        3'b000
`define LOAD_BU       3'b100

`endif

/* design/soc_bus_pkg.sv */
package soc_bus_pkg;

    // One bus address, seen whole or as word index plus byte offset
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [29:0] word_idx;
            logic [1:0]  byte_off;
        } word;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u   addr;
        logic [63:0] wdata;
        logic        rd_en;
        logic        wr_en;
        logic [2:0]  load_kind;
    } bus_req_t;

    // Target selects, at most one set per request
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
        logic sd_addr;
        logic sd_read;
        logic sd_ready;
        logic sd_avail;
        logic sd_buf;
    } dev_sel_t;

    typedef struct packed {
        logic     valid;
        bus_req_t req;
        dev_sel_t sel;
    } stage_req_t;

    typedef struct packed {
        logic        rd_valid;
        logic [31:0] data;
        logic [1:0]  byte_off;
        logic [2:0]  load_kind;
        logic        ram_hit;
    } access_rslt_t;

    typedef struct packed {
        logic [63:0] data;
        logic        done;
    } bus_rsp_t;

endpackage

/* design/bus_decode_stage.sv */
`timescale 1ns/1ps
`include "soc_bus_defs.svh"

module bus_decode_stage (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  soc_bus_pkg::bus_req_t   req,
    output soc_bus_pkg::stage_req_t stage_out
);

    logic                  req_active;
    soc_bus_pkg::dev_sel_t sel_d;
    logic                  valid_q;
    soc_bus_pkg::bus_req_t req_q;
    soc_bus_pkg::dev_sel_t sel_q;

    assign req_active = req.rd_en | req.wr_en;

    // Address decode on the full byte address
    always_comb begin
        sel_d          = '0;
        sel_d.ram      = (req.addr.full >= `RAM_BASE) &&
                         (req.addr.full < (`RAM_BASE + (`RAM_WORDS * 4)));
        sel_d.key      = (req.addr.full == `KEY_ADDR);
        sel_d.uart     = (req.addr.full == `UART_ADDR);
        sel_d.sd_addr  = (req.addr.full == `SD_ADDR_REG);
        sel_d.sd_read  = (req.addr.full == `SD_READ_REG);
        sel_d.sd_ready = (req.addr.full == `SD_READY_REG);
        sel_d.sd_avail = (req.addr.full == `SD_AVAIL_REG);
        sel_d.sd_buf   = (req.addr.full >= `SD_BUF_BASE) &&
                         (req.addr.full < (`SD_BUF_BASE + `SD_BUF_BYTES));
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_active;
        end
    end

    // Request and selects only move when a strobe is present
    always_ff @(posedge CLOCK_50) begin
        if (req_active) begin
            req_q <= req;
            sel_q <= sel_d;
        end
    end

    assign stage_out = '{valid: valid_q, req: req_q, sel: sel_q};

endmodule

/* design/bus_access_stage.sv */
`timescale 1ns/1ps
`include "soc_bus_defs.svh"

module bus_access_stage (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  soc_bus_pkg::stage_req_t   stage_in,
    input  logic [7:0]                key_code,
    input  logic                      sd_ready,
    input  logic                      sd_avail,
    input  logic [7:0]                sd_buf_byte,
    output logic [8:0]                sd_buf_index,
    output logic                      sd_rd_start,
    output logic [31:0]               sd_addr,
    output logic                      uart_write,
    output logic [7:0]                uart_data,
    output soc_bus_pkg::access_rslt_t rslt
);

    logic [31:0] ram [`RAM_WORDS];

    logic        wr;
    logic        rd;
    logic [29:0] ram_word;
    logic [9:0]  ram_idx;
    logic [31:0] buf_off;
    logic [31:0] rd_word;

    logic        rd_valid_q;
    logic [31:0] data_q;
    logic [1:0]  byte_off_q;
    logic [2:0]  load_kind_q;
    logic        ram_hit_q;

    assign wr = stage_in.valid & stage_in.req.wr_en;
    assign rd = stage_in.valid & stage_in.req.rd_en;

    // RAM uses the word view, relative to the region start
    assign ram_word = stage_in.req.addr.word.word_idx - 30'(`RAM_BASE >> 2);
    assign ram_idx  = ram_word[9:0];

    // Byte position inside the SD sector window
    assign buf_off      = stage_in.req.addr.full - `SD_BUF_BASE;
    assign sd_buf_index = buf_off[8:0];

    // Raw read word, unmapped reads give zero
    always_comb begin
        rd_word = '0;
        if (stage_in.sel.ram) begin
            rd_word = ram[ram_idx];
        end else if (stage_in.sel.key) begin
            rd_word = {24'd0, key_code};
        end else if (stage_in.sel.sd_ready) begin
            rd_word = {31'd0, sd_ready};
        end else if (stage_in.sel.sd_avail) begin
            rd_word = {31'd0, sd_avail};
        end else if (stage_in.sel.sd_buf) begin
            rd_word = {24'd0, sd_buf_byte};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_valid_q  <= 1'b0;
            sd_rd_start <= 1'b0;
            uart_write  <= 1'b0;
            sd_addr     <= '0;
        end else begin
            rd_valid_q  <= rd;
            sd_rd_start <= wr & stage_in.sel.sd_read;
            uart_write  <= wr & stage_in.sel.uart;
            if (wr && stage_in.sel.sd_addr) begin
                sd_addr <= stage_in.req.wdata[31:0];
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr && stage_in.sel.ram) begin
            ram[ram_idx] <= stage_in.req.wdata[31:0];
        end
        if (wr && stage_in.sel.uart) begin
            uart_data <= stage_in.req.wdata[7:0];
        end
        // Load info rides along for the align stage
        data_q      <= rd_word;
        byte_off_q  <= stage_in.req.addr.word.byte_off;
        load_kind_q <= stage_in.req.load_kind;
        ram_hit_q   <= stage_in.sel.ram;
    end

    assign rslt = '{
        rd_valid:  rd_valid_q,
        data:      data_q,
        byte_off:  byte_off_q,
        load_kind: load_kind_q,
        ram_hit:   ram_hit_q
    };

endmodule

/* design/load_align_stage.sv */
`timescale 1ns/1ps
`include "soc_bus_defs.svh"

module load_align_stage (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  soc_bus_pkg::access_rslt_t rslt,
    output soc_bus_pkg::bus_rsp_t     rsp
);

    logic [7:0]  sel_byte;
    logic [63:0] aligned;
    logic [63:0] data_q;
    logic        done_q;

    // Little-endian byte pick
    always_comb begin
        case (rslt.byte_off)
            2'd0:    sel_byte = rslt.data[7:0];
            2'd1:    sel_byte = rslt.data[15:8];
            2'd2:    sel_byte = rslt.data[23:16];
            default: sel_byte = rslt.data[31:24];
        endcase
    end

    always_comb begin
        aligned = {32'd0, rslt.data};
        if (rslt.ram_hit && (rslt.load_kind == `LOAD_B)) begin
            aligned = {{56{sel_byte[7]}}, sel_byte};
        end else if (rslt.ram_hit && (rslt.load_kind == `LOAD_BU)) begin
            aligned = {56'd0, sel_byte};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            done_q <= 1'b0;
        end else begin
            done_q <= rslt.rd_valid;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        data_q <= aligned;
    end

    assign rsp = '{data: data_q, done: done_q};

endmodule

/* design/sd_sector_buffer.sv */
`timescale 1ns/1ps
`include "soc_bus_defs.svh"

module sd_sector_buffer (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       byte_available,
    input  logic [7:0] din,
    input  logic [8:0] rd_index,
    output logic [7:0] rd_byte,
    output logic       avail
);

    logic [7:0] sector [`SD_BUF_BYTES];

    logic       byte_available_d;
    logic       capture;
    logic [8:0] wr_index;

    // New byte on each rising edge of the controller flag
    assign capture = byte_available & ~byte_available_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_available_d <= 1'b0;
            wr_index         <= '0;
            avail            <= 1'b0;
        end else begin
            byte_available_d <= byte_available;
            if (capture) begin
                // 9-bit index wraps to 0 after byte 511
                wr_index <= wr_index + 9'd1;
                if (wr_index == 9'd0) begin
                    avail <= 1'b0;
                end
                if (wr_index == 9'(`SD_BUF_BYTES - 1)) begin
                    avail <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (capture) begin
            sector[wr_index] <= din;
        end
    end

    assign rd_byte = sector[rd_index];

endmodule

/* design/key_irq_ctrl.sv */
`timescale 1ns/1ps

module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       interrupt_ack,
    output logic [7:0] key_code,
    output logic [3:0] interrupt_vector
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code         <= '0;
            interrupt_vector <= '0;
        end else begin
            if (key_valid) begin
                key_code <= key_ascii;
            end
            // Any nonzero code raises the keyboard vector
            if (key_valid && (key_ascii != 8'd0)) begin
                interrupt_vector <= 4'd1;
            end
            // Ack takes priority over a new key
            if (interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end
        end
    end

endmodule

/* design/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [31:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_read_enable,
    input  logic        bus_write_enable,
    input  logic [2:0]  bus_read_type,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    input  logic        key_valid,
    input  logic [7:0]  key_ascii,
    input  logic        interrupt_ack,
    output logic [3:0]  interrupt_vector,
    input  logic        sd_byte_available,
    input  logic [7:0]  sd_dout,
    input  logic        sd_ready,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr,
    output logic        uart_write,
    output logic [7:0]  uart_data
);

    soc_bus_pkg::bus_req_t     req;
    soc_bus_pkg::stage_req_t   stage_req;
    soc_bus_pkg::access_rslt_t access_rslt;
    soc_bus_pkg::bus_rsp_t     rsp;

    logic [7:0] key_code;
    logic [8:0] sd_buf_index;
    logic [7:0] sd_buf_byte;
    logic       sd_avail;

    // Master strobes packed into one request
    assign req = '{
        addr:      bus_address,
        wdata:     bus_write_data,
        rd_en:     bus_read_enable,
        wr_en:     bus_write_enable,
        load_kind: bus_read_type
    };

    bus_decode_stage u_decode (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .req       (req),
        .stage_out (stage_req)
    );

    bus_access_stage u_access (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .stage_in     (stage_req),
        .key_code     (key_code),
        .sd_ready     (sd_ready),
        .sd_avail     (sd_avail),
        .sd_buf_byte  (sd_buf_byte),
        .sd_buf_index (sd_buf_index),
        .sd_rd_start  (sd_rd_start),
        .sd_addr      (sd_addr),
        .uart_write   (uart_write),
        .uart_data    (uart_data),
        .rslt         (access_rslt)
    );

    load_align_stage u_align (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .rslt     (access_rslt),
        .rsp      (rsp)
    );

    sd_sector_buffer u_sd_buf (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .byte_available (sd_byte_available),
        .din            (sd_dout),
        .rd_index       (sd_buf_index),
        .rd_byte        (sd_buf_byte),
        .avail          (sd_avail)
    );

    key_irq_ctrl u_key (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_valid        (key_valid),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .key_code         (key_code),
        .interrupt_vector (interrupt_vector)
    );

    assign bus_read_data = rsp.data;
    assign bus_read_done = rsp.done;

endmodule

/* tests/tb_soc_bus.sv */
`timescale 1ns/1ps
`include "soc_bus_defs.svh"

module tb_soc_bus;

    localparam int CLK_PERIOD = 8;
    localparam logic [2:0] LOAD_WORD = 3'b010;
    localparam int READ_TIMEOUT = 10;

    // Rough cycle budget per test, SD streaming dominates
    localparam int RESET_CYCLES = 16;
    localparam int RAM_TEST_CYCLES = 80;
    localparam int BYTE_TEST_CYCLES = 50;
    localparam int KEY_TEST_CYCLES = 40;
    localparam int SD_TEST_CYCLES = `SD_BUF_BYTES * 4 + 150;
    localparam int UART_TEST_CYCLES = 40;
    localparam int UNMAPPED_TEST_CYCLES = 50;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + RAM_TEST_CYCLES + BYTE_TEST_CYCLES +
        KEY_TEST_CYCLES + SD_TEST_CYCLES + UART_TEST_CYCLES + UNMAPPED_TEST_CYCLES);

    logic        CLOCK_50;
    logic        KEY0;
    logic [31:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_read_enable;
    logic        bus_write_enable;
    logic [2:0]  bus_read_type;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        key_valid;
    logic [7:0]  key_ascii;
    logic        interrupt_ack;
    logic [3:0]  interrupt_vector;
    logic        sd_byte_available;
    logic [7:0]  sd_dout;
    logic        sd_ready;
    logic        sd_rd_start;
    logic [31:0] sd_addr;
    logic        uart_write;
    logic [7:0]  uart_data;

    string       test_name;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [7:0]  sd_bytes [$];

    soc_bus_top UUT (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_read_enable   (bus_read_enable),
        .bus_write_enable  (bus_write_enable),
        .bus_read_type     (bus_read_type),
        .bus_read_data     (bus_read_data),
        .bus_read_done     (bus_read_done),
        .key_valid         (key_valid),
        .key_ascii         (key_ascii),
        .interrupt_ack     (interrupt_ack),
        .interrupt_vector  (interrupt_vector),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .sd_ready          (sd_ready),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .uart_write        (uart_write),
        .uart_data         (uart_data)
    );

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic report_test;
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [63:0] data);
        @(negedge CLOCK_50);
        bus_address = addr;
        bus_write_data = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [2:0] kind,
                            output logic [63:0] data);
        int waited;
        @(negedge CLOCK_50);
        bus_address = addr;
        bus_read_type = kind;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        waited = 1;
        while (!bus_read_done && waited < READ_TIMEOUT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        data = '0;
        if (bus_read_done) begin
            data = bus_read_data;
        end else begin
            $display("Timeout in %s: no read_done for read of address %h", test_name, addr);
            error_count++;
            test_errors++;
        end
    endtask

    // One byte every 4 cycles, flag high for two of them
    task automatic sd_send_sector;
        int i;
        sd_bytes.delete();
        for (i = 0; i < `SD_BUF_BYTES; i++) begin
            sd_bytes.push_back(8'($urandom));
            @(negedge CLOCK_50);
            sd_dout = sd_bytes[i];
            sd_byte_available = 1'b1;
            repeat (2) @(negedge CLOCK_50);
            sd_byte_available = 1'b0;
            @(negedge CLOCK_50);
        end
    endtask

    task automatic ram_word_test;
        int          i;
        int          idx;
        logic [31:0] addrs [$];
        logic [31:0] words [$];
        logic [63:0] wdata;
        logic [63:0] data;
        begin_test("ram_words");
        for (i = 0; i < 8; i++) begin
            idx = i * 128 + int'($urandom % 128);
            wdata = {$urandom, $urandom};
            addrs.push_back(`RAM_BASE + idx * 4);
            words.push_back(wdata[31:0]);
            bus_write(addrs[i], wdata);
        end
        for (i = 0; i < 8; i++) begin
            bus_read(addrs[i], LOAD_WORD, data);
            check_value($sformatf("word %0d", i), {32'd0, words[i]}, data);
        end
        // Three reads on consecutive cycles, each done three cycles later
        for (i = 0; i < 6; i++) begin
            @(negedge CLOCK_50);
            if (i >= 3) begin
                check_value($sformatf("pipelined done %0d", i - 3), 64'd1,
                            {63'd0, bus_read_done});
                check_value($sformatf("pipelined data %0d", i - 3), {32'd0, words[i - 3]},
                            bus_read_data);
            end else begin
                check_value("early done", 64'd0, {63'd0, bus_read_done});
            end
            bus_read_enable = 1'b0;
            if (i < 3) begin
                bus_address = addrs[i];
                bus_read_type = LOAD_WORD;
                bus_read_enable = 1'b1;
            end
        end
        report_test();
    endtask

    task automatic byte_load_test;
        int          off;
        logic [31:0] word;
        logic [7:0]  b;
        logic [63:0] data;
        begin_test("byte_loads");
        word = 32'h80F1_7F23;
        bus_write(`RAM_BASE + 32'h100, {32'hDEAD_BEEF, word});
        for (off = 0; off < 4; off++) begin
            b = word[8 * off +: 8];
            bus_read(`RAM_BASE + 32'h100 + off, `LOAD_B, data);
            check_value($sformatf("signed byte %0d", off), {{56{b[7]}}, b}, data);
            bus_read(`RAM_BASE + 32'h100 + off, `LOAD_BU, data);
            check_value($sformatf("unsigned byte %0d", off), {56'd0, b}, data);
        end
        report_test();
    endtask

    task automatic keyboard_test;
        logic [63:0] data;
        begin_test("keyboard");
        @(negedge CLOCK_50);
        key_ascii = 8'h41;
        key_valid = 1'b1;
        @(negedge CLOCK_50);
        key_valid = 1'b0;
        check_value("vector after key", 64'd1, {60'd0, interrupt_vector});
        bus_read(`KEY_ADDR, LOAD_WORD, data);
        check_value("key code", 64'h41, data);
        @(negedge CLOCK_50);
        interrupt_ack = 1'b1;
        @(negedge CLOCK_50);
        interrupt_ack = 1'b0;
        check_value("vector after ack", 64'd0, {60'd0, interrupt_vector});
        // Zero code is latched but raises nothing
        key_ascii = 8'h00;
        key_valid = 1'b1;
        @(negedge CLOCK_50);
        key_valid = 1'b0;
        check_value("vector after zero code", 64'd0, {60'd0, interrupt_vector});
        bus_read(`KEY_ADDR, LOAD_WORD, data);
        check_value("zero code", 64'd0, data);
        report_test();
    endtask

    task automatic sd_sector_test;
        int          i;
        int          pulses;
        int          idx;
        logic [63:0] data;
        begin_test("sd_sector");
        bus_write(`SD_ADDR_REG, 64'h0000_0000_0001_2340);
        @(negedge CLOCK_50);
        check_value("sd_addr", 64'h0001_2340, {32'd0, sd_addr});
        bus_write(`SD_READ_REG, 64'd1);
        pulses = 0;
        repeat (5) begin
            @(negedge CLOCK_50);
            if (sd_rd_start) pulses++;
        end
        check_value("rd_start pulses", 64'd1, 64'(pulses));
        bus_read(`SD_AVAIL_REG, LOAD_WORD, data);
        check_value("avail before sector", 64'd0, data);
        sd_send_sector();
        bus_read(`SD_AVAIL_REG, LOAD_WORD, data);
        check_value("avail after sector", 64'd1, data);
        for (i = 0; i < 8; i++) begin
            idx = (i < 4) ? (i * 170) : int'($urandom % `SD_BUF_BYTES);
            if (i == 3) idx = `SD_BUF_BYTES - 1;
            bus_read(`SD_BUF_BASE + idx, LOAD_WORD, data);
            check_value($sformatf("buffer byte %0d", idx), {56'd0, sd_bytes[idx]}, data);
        end
        sd_ready = 1'b1;
        bus_read(`SD_READY_REG, LOAD_WORD, data);
        check_value("ready high", 64'd1, data);
        sd_ready = 1'b0;
        bus_read(`SD_READY_REG, LOAD_WORD, data);
        check_value("ready low", 64'd0, data);
        report_test();
    endtask

    task automatic uart_test;
        int          i;
        int          pulses;
        logic [63:0] wdata;
        logic [7:0]  seen;
        begin_test("uart");
        for (i = 0; i < 3; i++) begin
            wdata = {$urandom, $urandom};
            bus_write(`UART_ADDR, wdata);
            pulses = 0;
            seen = '0;
            repeat (4) begin
                @(negedge CLOCK_50);
                if (uart_write) begin
                    pulses++;
                    seen = uart_data;
                end
            end
            check_value($sformatf("pulses %0d", i), 64'd1, 64'(pulses));
            check_value($sformatf("data %0d", i), {56'd0, wdata[7:0]}, {56'd0, seen});
        end
        report_test();
    endtask

    task automatic unmapped_test;
        logic [63:0] data;
        begin_test("unmapped");
        bus_write(`RAM_BASE, 64'h0000_0000_1111_2222);
        bus_write(`RAM_BASE + 32'hFFC, 64'h0000_0000_3333_4444);
        bus_read(32'h0000_4000, LOAD_WORD, data);
        check_value("read 4000", 64'd0, data);
        bus_read(32'h0000_8008, LOAD_WORD, data);
        check_value("read 8008", 64'd0, data);
        // Just outside both ends of the RAM window
        bus_write(`RAM_BASE - 32'd4, 64'hFFFF_FFFF_FFFF_FFFF);
        bus_write(`RAM_BASE + 32'h1000, 64'hFFFF_FFFF_FFFF_FFFF);
        bus_read(`RAM_BASE, LOAD_WORD, data);
        check_value("first word kept", 64'h1111_2222, data);
        bus_read(`RAM_BASE + 32'hFFC, LOAD_WORD, data);
        check_value("last word kept", 64'h3333_4444, data);
        report_test();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        bus_read_type = LOAD_WORD;
        key_valid = 1'b0;
        key_ascii = '0;
        interrupt_ack = 1'b0;
        sd_byte_available = 1'b0;
        sd_dout = '0;
        sd_ready = 1'b0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32));
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        ram_word_test();
        byte_load_test();
        keyboard_test();
        sd_sector_test();
        uart_test();
        unmapped_test();
        $display("Tests run: %0d, tests failed: %0d, check failures: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
design/soc_bus_pkg.sv
design/bus_decode_stage.sv
design/bus_access_stage.sv
design/load_align_stage.sv
design/sd_sector_buffer.sv
design/key_irq_ctrl.sv
design/soc_bus_top.sv
tests/tb_soc_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -f build.f --top-module tb_soc_bus -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_soc_bus" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG"
    exit 1
fi
